//--- logic/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Major opcodes handled by the core
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef enum logic {
        FWD_REG,  // Value read in decode
        FWD_WB    // Value in write-back
    } fwd_sel_e;

    // ====================
    // Instruction formats
    // ====================
    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [19:0]           imm;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                  imm12;
        logic [5:0]            imm10_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm4_1;
        logic                  imm11;
        logic [6:0]            opcode;
    } b_fmt_t;

    typedef struct packed {
        logic                  imm20;
        logic [9:0]            imm10_1;
        logic                  imm11;
        logic [7:0]            imm19_12;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        u_fmt_t u_fmt;
        b_fmt_t b_fmt;
        j_fmt_t j_fmt;
    } rv_inst_u;

endpackage

`default_nettype wire

//--- logic/exe_ctrl_if.sv
`default_nettype none

interface exe_ctrl_if import rv_pkg::*; ();

    // Control for the instruction now in execute
    alu_op_e  alu_op;
    logic     alu_src_imm;   // Operand b from immediate
    logic     is_lui;
    logic     is_jal;
    logic     is_branch;
    logic     branch_ne;     // BNE when set, else BEQ
    logic     valid;

    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;

    logic     flush;         // Redirect, kills the two younger slots
    logic     branch_taken;

    modport ctrl (
        output alu_op, alu_src_imm, is_lui, is_jal, is_branch, branch_ne, valid,
        output fwd_a, fwd_b, flush,
        input  branch_taken
    );

    modport exe (
        input  alu_op, alu_src_imm, is_lui, is_jal, is_branch, branch_ne, valid,
        input  fwd_a, fwd_b,
        output branch_taken
    );

endinterface

`default_nettype wire

//--- logic/fetch_unit.sv
`default_nettype none

module fetch_unit import rv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            flush_i,
    input  logic [XLEN-1:0] redirect_pc_i,
    output logic [XLEN-1:0] imem_addr_o,
    input  logic [XLEN-1:0] imem_data_i,
    output rv_inst_u        inst_id_o,
    output logic [XLEN-1:0] pc_id_o
);

    localparam logic [XLEN-1:0] NOP_INST = 32'h0000_0013;  // ADDI x0, x0, 0

    logic [XLEN-1:0] pc_q;
    rv_inst_u        inst_q;
    logic [XLEN-1:0] pc_id_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= RESET_PC;
        end else if (flush_i) begin
            pc_q <= redirect_pc_i;
        end else begin
            pc_q <= pc_q + XLEN'(4);
        end
    end

    // Fetch/decode register
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            inst_q <= NOP_INST;
        end else begin
            inst_q <= flush_i ? NOP_INST : imem_data_i;  // Squash wrong-path fetch
        end
    end

    always_ff @(posedge clk) begin
        pc_id_q <= pc_q;
    end

    assign imem_addr_o = pc_q;
    assign inst_id_o   = inst_q;
    assign pc_id_o     = pc_id_q;

    // Redirect targets come from execute
    a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n_i)
        pc_q[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- logic/rv_controller.sv
`default_nettype none

module rv_controller import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  rv_inst_u              inst_id_i,
    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o,
    output logic [REG_ADDR_W-1:0] wb_rd_o,
    output logic                  wb_valid_o,
    exe_ctrl_if.ctrl              ex_bus
);

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd_dec;

    alu_op_e               dec_alu_op;
    logic                  dec_src_imm;
    logic                  dec_lui;
    logic                  dec_jal;
    logic                  dec_branch;
    logic                  dec_valid;
    logic                  dec_we;

    logic                  we_ex_q;   // Execute stage writes rd
    logic [REG_ADDR_W-1:0] rd_ex_q;
    logic [REG_ADDR_W-1:0] rs1_ex_q;
    logic [REG_ADDR_W-1:0] rs2_ex_q;
    logic                  wb_valid_q;
    logic [REG_ADDR_W-1:0] wb_rd_q;

    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // ====================
    // Decode
    // ====================
    assign opcode = inst_id_i.r_fmt.opcode;
    assign funct3 = inst_id_i.r_fmt.funct3;
    assign rd_dec = inst_id_i.r_fmt.rd;
    assign rs1_o  = inst_id_i.r_fmt.rs1;
    assign rs2_o  = inst_id_i.r_fmt.rs2;

    always_comb begin
        dec_alu_op  = ALU_ADD;
        dec_src_imm = 1'b0;
        dec_lui     = 1'b0;
        dec_jal     = 1'b0;
        dec_branch  = 1'b0;
        dec_valid   = 1'b0;
        dec_we      = 1'b0;
        case (opcode)
            OP_REG: begin
                dec_valid  = 1'b1;
                dec_we     = 1'b1;
                dec_alu_op = alu_from_funct3(funct3, inst_id_i.r_fmt.funct7[5]);
            end
            OP_IMM: begin
                dec_valid   = 1'b1;
                dec_we      = 1'b1;
                dec_src_imm = 1'b1;
                // Only SRAI uses imm[10] as a selector
                dec_alu_op  = alu_from_funct3(funct3,
                                  (funct3 == 3'b101) & inst_id_i.i_fmt.imm[10]);
            end
            OP_LUI: begin
                dec_valid = 1'b1;
                dec_we    = 1'b1;
                dec_lui   = 1'b1;
            end
            OP_JAL: begin
                dec_valid = 1'b1;
                dec_we    = 1'b1;
                dec_jal   = 1'b1;
            end
            OP_BRANCH: begin
                dec_valid  = (funct3[2:1] == 2'b00);  // BEQ and BNE only
                dec_branch = 1'b1;
            end
            default: ;
        endcase
    end

    // ====================
    // Stage registers
    // ====================
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_bus.valid       <= 1'b0;
            ex_bus.alu_op      <= ALU_ADD;
            ex_bus.alu_src_imm <= 1'b0;
            ex_bus.is_lui      <= 1'b0;
            ex_bus.is_jal      <= 1'b0;
            ex_bus.is_branch   <= 1'b0;
            ex_bus.branch_ne   <= 1'b0;
            we_ex_q            <= 1'b0;
            wb_valid_q         <= 1'b0;
        end else begin
            ex_bus.valid       <= dec_valid & ~ex_bus.flush;  // Kill on redirect
            ex_bus.alu_op      <= dec_alu_op;
            ex_bus.alu_src_imm <= dec_src_imm;
            ex_bus.is_lui      <= dec_lui;
            ex_bus.is_jal      <= dec_jal;
            ex_bus.is_branch   <= dec_branch;
            ex_bus.branch_ne   <= funct3[0];
            we_ex_q            <= dec_we & (rd_dec != '0) & ~ex_bus.flush;
            wb_valid_q         <= ex_bus.valid & we_ex_q;
        end
    end

    always_ff @(posedge clk) begin
        rd_ex_q  <= rd_dec;
        rs1_ex_q <= rs1_o;
        rs2_ex_q <= rs2_o;
        wb_rd_q  <= rd_ex_q;
    end

    // Forward when write-back targets an execute source
    assign ex_bus.fwd_a = (wb_valid_q && wb_rd_q != '0 && wb_rd_q == rs1_ex_q) ? FWD_WB : FWD_REG;
    assign ex_bus.fwd_b = (wb_valid_q && wb_rd_q != '0 && wb_rd_q == rs2_ex_q) ? FWD_WB : FWD_REG;

    assign ex_bus.flush = ex_bus.branch_taken;
    assign wb_valid_o   = wb_valid_q;
    assign wb_rd_o      = wb_rd_q;

    // The slot behind a redirect reaches execute dead
    a_flush_valid: assert property (@(posedge clk) disable iff (!arst_n_i)
        ex_bus.flush |=> !ex_bus.valid);

endmodule

`default_nettype wire

//--- logic/reg_file.sv
`default_nettype none

module reg_file import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic [REG_ADDR_W-1:0] rs1_i,
    input  logic [REG_ADDR_W-1:0] rs2_i,
    input  logic                  wb_valid_i,
    input  logic [REG_ADDR_W-1:0] wb_rd_i,
    input  logic [XLEN-1:0]       wb_data_i,
    output logic [XLEN-1:0]       rdata1_o,
    output logic [XLEN-1:0]       rdata2_o
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    // Read with write-through from the same cycle
    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (wb_valid_i && wb_rd_i == addr) begin
            return wb_data_i;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid_i && wb_rd_i != '0) begin
            regs[wb_rd_i] <= wb_data_i;  // x0 stays zero
        end
    end

    assign rdata1_o = read_port(rs1_i);
    assign rdata2_o = read_port(rs2_i);

    // Controller never presents a write to x0
    a_no_x0_write: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_valid_i |-> wb_rd_i != '0);

endmodule

`default_nettype wire

//--- logic/imm_gen.sv
`default_nettype none

module imm_gen import rv_pkg::*; (
    input  rv_inst_u        inst_i,
    output logic [XLEN-1:0] imm_o
);

    always_comb begin
        case (inst_i.r_fmt.opcode)
            OP_IMM: begin
                imm_o = {{20{inst_i.i_fmt.imm[11]}}, inst_i.i_fmt.imm};
            end
            OP_LUI: begin
                imm_o = {inst_i.u_fmt.imm, 12'b0};
            end
            OP_BRANCH: begin
                imm_o = {{19{inst_i.b_fmt.imm12}}, inst_i.b_fmt.imm12,
                         inst_i.b_fmt.imm11, inst_i.b_fmt.imm10_5,
                         inst_i.b_fmt.imm4_1, 1'b0};
            end
            OP_JAL: begin
                imm_o = {{11{inst_i.j_fmt.imm20}}, inst_i.j_fmt.imm20,
                         inst_i.j_fmt.imm19_12, inst_i.j_fmt.imm11,
                         inst_i.j_fmt.imm10_1, 1'b0};
            end
            default: imm_o = '0;  // R-type has no immediate
        endcase
    end

endmodule

`default_nettype wire

//--- logic/execute_unit.sv
`default_nettype none

module execute_unit import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n_i,
    exe_ctrl_if.exe               ex_bus,
    input  logic [XLEN-1:0]       pc_id_i,
    input  logic [XLEN-1:0]       rdata1_i,
    input  logic [XLEN-1:0]       rdata2_i,
    input  logic [XLEN-1:0]       imm_i,
    input  logic [REG_ADDR_W-1:0] wb_rd_i,
    output logic [XLEN-1:0]       redirect_pc_o,
    output logic [XLEN-1:0]       wb_data_o
);

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] rs1_val_q;
    logic [XLEN-1:0] rs2_val_q;
    logic [XLEN-1:0] imm_q;
    logic [XLEN-1:0] wb_data_q;

    logic [XLEN-1:0] wb_fwd;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] rs2_fwd;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] result;
    logic            src_equal;

    // Operands from decode
    always_ff @(posedge clk) begin
        pc_q      <= pc_id_i;
        rs1_val_q <= rdata1_i;
        rs2_val_q <= rdata2_i;
        imm_q     <= imm_i;
    end

    // ====================
    // Forwarding
    // ====================
    assign wb_fwd  = (wb_rd_i != '0) ? wb_data_q : '0;  // x0 never forwards a value
    assign op_a    = (ex_bus.fwd_a == FWD_WB) ? wb_fwd : rs1_val_q;
    assign rs2_fwd = (ex_bus.fwd_b == FWD_WB) ? wb_fwd : rs2_val_q;
    assign op_b    = ex_bus.alu_src_imm ? imm_q : rs2_fwd;

    // ====================
    // ALU
    // ====================
    always_comb begin
        case (ex_bus.alu_op)
            ALU_ADD:  alu_res = op_a + op_b;
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_SLL:  alu_res = op_a << op_b[4:0];
            ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SRL:  alu_res = op_a >> op_b[4:0];
            ALU_SRA:  alu_res = $unsigned($signed(op_a) >>> op_b[4:0]);
            ALU_OR:   alu_res = op_a | op_b;
            default:  alu_res = op_a & op_b;
        endcase
    end

    always_comb begin
        if (ex_bus.is_lui) begin
            result = imm_q;
        end else if (ex_bus.is_jal) begin
            result = pc_q + XLEN'(4);  // Link value
        end else begin
            result = alu_res;
        end
    end

    // Branch resolution, BNE inverts the compare
    assign src_equal           = (op_a == rs2_fwd);
    assign ex_bus.branch_taken = ex_bus.valid &
                                 (ex_bus.is_jal |
                                  (ex_bus.is_branch & (src_equal ^ ex_bus.branch_ne)));
    assign redirect_pc_o       = pc_q + imm_q;

    // Execute/write-back register
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_data_q <= '0;
        end else begin
            wb_data_q <= result;
        end
    end

    assign wb_data_o = wb_data_q;

    a_alu_op_known: assert property (@(posedge clk) disable iff (!arst_n_i)
        ex_bus.valid |-> !$isunknown(ex_bus.alu_op));

endmodule

`default_nettype wire

//--- logic/rv_core_top.sv
`default_nettype none

module rv_core_top import rv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic                  clk,
    input  logic                  arst_n_i,

    // Instruction memory, combinational read
    output logic [XLEN-1:0]       imem_addr_o,
    input  logic [XLEN-1:0]       imem_data_i,

    // Retire port
    output logic                  retire_valid_o,
    output logic [REG_ADDR_W-1:0] retire_rd_o,
    output logic [XLEN-1:0]       retire_data_o
);

    exe_ctrl_if ex_bus ();

    rv_inst_u              inst_id;
    logic [XLEN-1:0]       pc_id;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [XLEN-1:0]       rdata1;
    logic [XLEN-1:0]       rdata2;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       redirect_pc;

    // Write-back bus
    logic                  wb_valid;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]       wb_data;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) fetch_unit_i (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .flush_i       (ex_bus.flush),
        .redirect_pc_i (redirect_pc),
        .imem_addr_o   (imem_addr_o),
        .imem_data_i   (imem_data_i),
        .inst_id_o     (inst_id),
        .pc_id_o       (pc_id)
    );

    rv_controller rv_controller_i (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .inst_id_i  (inst_id),
        .rs1_o      (rs1),
        .rs2_o      (rs2),
        .wb_rd_o    (wb_rd),
        .wb_valid_o (wb_valid),
        .ex_bus     (ex_bus.ctrl)
    );

    reg_file reg_file_i (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .wb_valid_i (wb_valid),
        .wb_rd_i    (wb_rd),
        .wb_data_i  (wb_data),
        .rdata1_o   (rdata1),
        .rdata2_o   (rdata2)
    );

    imm_gen imm_gen_i (
        .inst_i (inst_id),
        .imm_o  (imm)
    );

    execute_unit execute_unit_i (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .ex_bus        (ex_bus.exe),
        .pc_id_i       (pc_id),
        .rdata1_i      (rdata1),
        .rdata2_i      (rdata2),
        .imm_i         (imm),
        .wb_rd_i       (wb_rd),
        .redirect_pc_o (redirect_pc),
        .wb_data_o     (wb_data)
    );

    assign retire_valid_o = wb_valid;
    assign retire_rd_o    = wb_rd;
    assign retire_data_o  = wb_data;

endmodule

`default_nettype wire

//--- tb/rv_core_tb.sv
`default_nettype none

module rv_core_tb import rv_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [XLEN-1:0] RESET_PC     = 32'h0000_0100;
    localparam logic [XLEN-1:0] NOP_INST     = 32'h0000_0013;
    localparam logic [31:0]     LCG_SEED     = 32'hb7fe;
    localparam int              HALF_PERIOD  = 4;
    localparam int              RESET_CYCLES = 5;
    localparam int              DRAIN_CYCLES = 8;
    localparam int              N_RANDOM     = 40;

    // ALU operation table where SUB and SRA set the alternate bit
    localparam logic [2:0] OP_F3 [10] = '{3'b000, 3'b000, 3'b001, 3'b010, 3'b011,
                                          3'b100, 3'b101, 3'b101, 3'b110, 3'b111};
    localparam logic       OP_ALT [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0,
                                           1'b0, 1'b0, 1'b1, 1'b0, 1'b0};

    logic                  clk;
    logic                  arst_n_i;
    logic [XLEN-1:0]       imem_addr_o;
    logic [XLEN-1:0]       imem_data_i = NOP_INST;
    logic                  retire_valid_o;
    logic [REG_ADDR_W-1:0] retire_rd_o;
    logic [XLEN-1:0]       retire_data_o;

    // Program image and per-address outcome from the reference run
    logic [31:0] imem [128];
    logic        taken_tbl [128];
    logic [31:0] target_tbl [128];
    int          prog_len = 0;

    // Expected retirements in architectural order
    logic [4:0]  exp_rd_arr [256];
    logic [31:0] exp_data_arr [256];
    logic [7:0]  exp_n = '0;
    logic [7:0]  ret_idx;
    logic [4:0]  head_rd;
    logic [31:0] head_data;

    // Fetch timing model
    logic        fd_valid;
    logic [31:0] fd_pc;
    logic        ex_valid;
    logic [31:0] ex_pc;
    logic        ex_taken;
    logic [31:0] ex_target;
    logic        fetch_armed;
    logic        exp_redirect;
    logic [31:0] exp_target;
    logic [31:0] prev_addr;

    int reset_errs    = 0;
    int fetch_errs    = 0;
    int redirect_errs = 0;
    int retire_errs   = 0;
    int extra_errs    = 0;
    int x0_errs       = 0;
    int timeout_cycles;

    rv_core_top #(
        .RESET_PC (RESET_PC)
    ) rv_core_top_i (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .imem_addr_o    (imem_addr_o),
        .imem_data_i    (imem_data_i),
        .retire_valid_o (retire_valid_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // ====================
    // Program helpers
    // ====================
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OP_IMM};
    endfunction

    function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OP_LUI};
    endfunction

    function automatic logic [31:0] branch_word(input int off, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3);
        logic [12:0] o;
        o = 13'(off);
        return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] jal_word(input int off, input logic [4:0] rd);
        logic [20:0] o;
        o = 21'(off);
        return {o[20], o[10:1], o[11], o[19:12], rd, OP_JAL};
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        if (addr < RESET_PC || addr >= RESET_PC + (prog_len << 2)) begin
            return NOP_INST;  // Wrong-path fetch past the end
        end
        return imem[7'((addr - RESET_PC) >> 2)];
    endfunction

    task automatic append_inst(input logic [31:0] inst);
        imem[7'(prog_len)] = inst;
        prog_len = prog_len + 1;
    endtask

    task automatic build_program();
        logic [31:0] rnd;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [3:0]  k;
        logic [11:0] imm12;
        int          pick;
        rnd = LCG_SEED;
        // Seed x1..x7 with LUI then a dependent ADDI
        for (int r = 1; r < 8; r++) begin
            rnd = lcg_next(rnd);
            append_inst(lui_word(rnd[31:12], 5'(r)));
            rnd = lcg_next(rnd);
            append_inst(i_type(rnd[31:20], 5'(r), 3'b000, 5'(r)));
        end
        for (int n = 0; n < N_RANDOM; n++) begin
            rnd  = lcg_next(rnd);
            rd   = {2'b00, rnd[10:8]};   // Small register set including x0
            rs1  = {2'b00, rnd[13:11]};
            rs2  = {2'b00, rnd[16:14]};
            if (n < 20) begin
                pick = n;                // First pass covers every form once
                rd   = 5'(n % 7 + 1);
            end else begin
                pick = int'(rnd[31:24]) % 20;
            end
            if (pick < 10) begin
                k = 4'(pick);
                append_inst(r_type({1'b0, OP_ALT[k], 5'b0}, rs2, rs1, OP_F3[k], rd));
            end else if (pick < 19) begin
                k = 4'(pick - 10);
                if (k >= 4'd1) begin
                    k = k + 4'd1;  // No SUBI
                end
                if (OP_F3[k] == 3'b001 || OP_F3[k] == 3'b101) begin
                    imm12 = {1'b0, OP_ALT[k], 5'b0, rnd[16:12]};
                end else begin
                    imm12 = rnd[23:12];
                end
                append_inst(i_type(imm12, rs1, OP_F3[k], rd));
            end else begin
                append_inst(lui_word(rnd[31:12], rd));
            end
        end
        // Fixed tail with branches, JAL and x0
        append_inst(i_type(12'd5, 5'd0, 3'b000, 5'd8));
        append_inst(i_type(12'd5, 5'd0, 3'b000, 5'd9));
        append_inst(branch_word(12, 5'd9, 5'd8, 3'b000));      // BEQ taken
        append_inst(i_type(12'd1, 5'd0, 3'b000, 5'd10));
        append_inst(i_type(12'd2, 5'd0, 3'b000, 5'd10));
        append_inst(branch_word(8, 5'd9, 5'd8, 3'b001));       // BNE not taken
        append_inst(i_type(12'd3, 5'd8, 3'b000, 5'd11));
        append_inst(branch_word(12, 5'd8, 5'd11, 3'b001));     // BNE taken
        append_inst(i_type(12'd7, 5'd0, 3'b000, 5'd12));
        append_inst(i_type(12'd8, 5'd0, 3'b000, 5'd12));
        append_inst(branch_word(8, 5'd8, 5'd11, 3'b000));      // BEQ not taken
        append_inst(jal_word(12, 5'd13));
        append_inst(i_type(12'd1, 5'd0, 3'b000, 5'd14));
        append_inst(i_type(12'd2, 5'd0, 3'b000, 5'd14));
        append_inst(i_type(12'd99, 5'd13, 3'b000, 5'd0));      // Writes x0
        append_inst(r_type(7'd0, 5'd12, 5'd11, 3'b000, 5'd0));
        append_inst(r_type(7'd0, 5'd13, 5'd0, 3'b000, 5'd15)); // Reads x0
        append_inst(r_type(7'd0, 5'd0, 5'd13, 3'b000, 5'd16));
        append_inst(jal_word(0, 5'd0));                        // Halt loop
    endtask

    // ====================
    // Reference model
    // ====================
    function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
                                               input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic run_reference();
        logic [31:0] xregs [32];
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] val;
        logic [6:0]  idx;
        logic        wr;
        logic        took;
        logic        halted;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            xregs[5'(i)] = '0;
        end
        for (int i = 0; i < 128; i++) begin
            taken_tbl[7'(i)] = 1'b0;
        end
        pc     = RESET_PC;
        halted = 1'b0;
        steps  = 0;
        while (!halted && steps < 1024) begin
            idx     = 7'((pc - RESET_PC) >> 2);
            inst    = imem[idx];
            a       = xregs[inst[19:15]];
            b       = xregs[inst[24:20]];
            next_pc = pc + 32'd4;
            wr      = 1'b0;
            took    = 1'b0;
            val     = '0;
            case (inst[6:0])
                OP_REG: begin
                    wr  = 1'b1;
                    val = alu_result(inst[14:12], inst[30], a, b);
                end
                OP_IMM: begin
                    wr  = 1'b1;
                    val = alu_result(inst[14:12], (inst[14:12] == 3'b101) & inst[30], a,
                                     {{20{inst[31]}}, inst[31:20]});
                end
                OP_LUI: begin
                    wr  = 1'b1;
                    val = {inst[31:12], 12'b0};
                end
                OP_JAL: begin
                    wr      = 1'b1;
                    took    = 1'b1;
                    val     = pc + 32'd4;
                    next_pc = pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                                    inst[30:21], 1'b0};
                end
                OP_BRANCH: begin
                    if ((a == b) != inst[12]) begin
                        took    = 1'b1;
                        next_pc = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                        inst[11:8], 1'b0};
                    end
                end
                default: ;
            endcase
            taken_tbl[idx]  = took;
            target_tbl[idx] = next_pc;
            if (wr && inst[11:7] != 5'd0) begin
                xregs[inst[11:7]]   = val;
                exp_rd_arr[exp_n]   = inst[11:7];
                exp_data_arr[exp_n] = val;
                exp_n               = exp_n + 8'd1;
            end
            halted = (next_pc == pc);
            pc     = next_pc;
            steps  = steps + 1;
        end
    endtask

    // Instruction memory answers within the cycle
    always @(negedge clk) begin
        imem_data_i <= fetch_word(imem_addr_o);
    end

    // ====================
    // Pipeline tracking
    // ====================
    assign ex_taken  = ex_valid && taken_tbl[7'((ex_pc - RESET_PC) >> 2)];
    assign ex_target = target_tbl[7'((ex_pc - RESET_PC) >> 2)];
    assign head_rd   = exp_rd_arr[ret_idx];
    assign head_data = exp_data_arr[ret_idx];

    always @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fd_valid     <= 1'b0;
            fd_pc        <= RESET_PC;
            ex_valid     <= 1'b0;
            ex_pc        <= RESET_PC;
            fetch_armed  <= 1'b0;
            exp_redirect <= 1'b0;
            exp_target   <= RESET_PC;
            prev_addr    <= RESET_PC;
            ret_idx      <= '0;
        end else begin
            fd_valid     <= ~ex_taken;             // Fetch slot killed by redirect
            fd_pc        <= imem_addr_o;
            ex_valid     <= fd_valid & ~ex_taken;
            ex_pc        <= fd_pc;
            fetch_armed  <= 1'b1;
            exp_redirect <= ex_taken;
            exp_target   <= ex_target;
            prev_addr    <= imem_addr_o;
            if (retire_valid_o) begin
                ret_idx <= ret_idx + 8'd1;
            end
        end
    end

    a_reset_state: assert property (@(posedge clk) disable iff (!arst_n_i)
        !fetch_armed |-> (imem_addr_o == RESET_PC && !retire_valid_o))
    else begin
        reset_errs = reset_errs + 1;
        $display("ERROR reset_state: expected addr=%08h valid=0, actual addr=%08h valid=%0b",
                 RESET_PC, $sampled(imem_addr_o), $sampled(retire_valid_o));
    end

    a_seq_fetch: assert property (@(posedge clk) disable iff (!arst_n_i)
        (fetch_armed && !exp_redirect) |-> imem_addr_o == prev_addr + 32'd4)
    else begin
        fetch_errs = fetch_errs + 1;
        $display("ERROR seq_fetch: expected addr=%08h, actual addr=%08h",
                 $sampled(prev_addr) + 32'd4, $sampled(imem_addr_o));
    end

    a_redirect_target: assert property (@(posedge clk) disable iff (!arst_n_i)
        (fetch_armed && exp_redirect) |-> imem_addr_o == exp_target)
    else begin
        redirect_errs = redirect_errs + 1;
        $display("ERROR redirect_target: expected addr=%08h, actual addr=%08h",
                 $sampled(exp_target), $sampled(imem_addr_o));
    end

    a_retire_expected: assert property (@(posedge clk) disable iff (!arst_n_i)
        retire_valid_o |-> ret_idx < exp_n)
    else begin
        extra_errs = extra_errs + 1;
        $display("Unexpected retirement to x%0d after all expected results were seen",
                 $sampled(retire_rd_o));
    end

    a_retire_match: assert property (@(posedge clk) disable iff (!arst_n_i)
        (retire_valid_o && ret_idx < exp_n) |->
            (retire_rd_o == head_rd && retire_data_o == head_data))
    else begin
        retire_errs = retire_errs + 1;
        $display("ERROR retire_match #%0d: expected x%0d=%08h, actual x%0d=%08h",
                 $sampled(ret_idx), $sampled(head_rd), $sampled(head_data),
                 $sampled(retire_rd_o), $sampled(retire_data_o));
    end

    a_x0_silent: assert property (@(posedge clk) disable iff (!arst_n_i)
        retire_valid_o |-> retire_rd_o != 5'd0)
    else begin
        x0_errs = x0_errs + 1;
        $display("ERROR x0_silent: expected rd!=0, actual rd=%0d", $sampled(retire_rd_o));
    end

    // ====================
    // Stimulus and end of run
    // ====================
    initial begin
        int cycles;
        int total;
        bit timed_out;
        arst_n_i = 1'b0;
        build_program();
        run_reference();
        timeout_cycles = prog_len * 4 + 50;
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n_i = 1'b1;
        cycles   = 0;
        while (ret_idx < exp_n && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles = cycles + 1;
        end
        timed_out = (ret_idx < exp_n);
        if (!timed_out) begin
            repeat (DRAIN_CYCLES) @(negedge clk);  // Catch stray retirements
        end
        total = reset_errs + fetch_errs + redirect_errs + retire_errs + extra_errs + x0_errs;
        $display("Errors: reset=%0d fetch=%0d redirect=%0d retire=%0d extra=%0d x0=%0d",
                 reset_errs, fetch_errs, redirect_errs, retire_errs, extra_errs, x0_errs);
        if (timed_out) begin
            $display("Timeout: only %0d of %0d results retired within %0d cycles",
                     ret_idx, exp_n, timeout_cycles);
        end
        if (!timed_out && total == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
logic/rv_pkg.sv
logic/exe_ctrl_if.sv
logic/fetch_unit.sv
logic/rv_controller.sv
logic/reg_file.sv
logic/imm_gen.sv
logic/execute_unit.sv
logic/rv_core_top.sv
tb/rv_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f tb.f --top-module rv_core_tb -o rv_core_tb

output=$(./obj_dir/rv_core_tb)
echo "$output"

if echo "$output" | grep -qx "Simulation PASSED"; then
    exit 0
else
    exit 1
fi
